//--- design/sound_pkg.sv
`default_nettype none

package sound_pkg;

	// AXI4-Lite port widths.
	localparam int axi_addr_w = 4;
	localparam int axi_data_w = 32;

	localparam int period_w = 11; // Reload value of the period divider.
	localparam int vol_w    = 4;  // Channel sample and volume.
	localparam int mix_w    = 5;  // Sum of two channel samples.
	localparam int duty_w   = 2;

	// One wave is a sequence of 32 phase steps.
	localparam int steps   = 32;
	localparam int phase_w = $clog2(steps);

	// Register map, byte addresses.
	localparam logic [axi_addr_w-1:0] reg_ch0_ctrl   = 4'h0;
	localparam logic [axi_addr_w-1:0] reg_ch0_period = 4'h4;
	localparam logic [axi_addr_w-1:0] reg_ch1_ctrl   = 4'h8;
	localparam logic [axi_addr_w-1:0] reg_ch1_period = 4'hC;

	// Field positions inside a ctrl register.
	localparam int ctrl_en_bit   = 0;
	localparam int ctrl_duty_lsb = 1;
	localparam int ctrl_vol_lsb  = 4;

	// First phase at which the output goes high, per duty setting.
	localparam logic [phase_w-1:0] thr_duty_50 = 5'd16; // Duty 0 and 3.
	localparam logic [phase_w-1:0] thr_duty_75 = 5'd8;  // Duty 1.
	localparam logic [phase_w-1:0] thr_duty_87 = 5'd4;  // Duty 2.

	localparam logic [1:0] axi_resp_okay   = 2'b00;
	localparam logic [1:0] axi_resp_slverr = 2'b10;

	typedef struct packed {
		logic                enable;
		logic [duty_w-1:0]   duty;
		logic [vol_w-1:0]    volume;
		logic [period_w-1:0] period;
	} pulse_cfg_t;

endpackage

`default_nettype wire

//--- design/sound_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sound_regs
	import sound_pkg::*;
(
	input  logic                  base_freq,
	input  logic                  rst_n,
	input  logic [axi_addr_w-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [axi_data_w-1:0] wdata,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [axi_addr_w-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [axi_data_w-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output pulse_cfg_t            cfg0,
	output pulse_cfg_t            cfg1
);

	logic                  wr_fire; // Address and data accepted this cycle.
	logic                  rd_fire;
	logic                  wr_hit;  // Write address is in the map.
	logic                  rd_hit;
	logic [axi_data_w-1:0] rd_word;

	// Merge the ctrl fields of a write into a channel configuration.
	function automatic pulse_cfg_t put_ctrl(input pulse_cfg_t cur,
		input logic [axi_data_w-1:0] d);
		pulse_cfg_t nxt;
		nxt        = cur;
		nxt.enable = d[ctrl_en_bit];
		nxt.duty   = d[ctrl_duty_lsb +: duty_w];
		nxt.volume = d[ctrl_vol_lsb +: vol_w];
		return nxt;
	endfunction

	function automatic logic [axi_data_w-1:0] get_ctrl(input pulse_cfg_t c);
		logic [axi_data_w-1:0] w;
		w                              = '0;
		w[ctrl_en_bit]                 = c.enable;
		w[ctrl_duty_lsb +: duty_w]     = c.duty;
		w[ctrl_vol_lsb +: vol_w]       = c.volume;
		return w;
	endfunction

	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	always_comb
	begin
		case (awaddr)
			reg_ch0_ctrl, reg_ch0_period, reg_ch1_ctrl, reg_ch1_period: wr_hit = 1'b1;
			default: wr_hit = 1'b0;
		endcase
	end

	// Unused bits and unmapped addresses read back as zero.
	always_comb
	begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (araddr)
			reg_ch0_ctrl:   rd_word = get_ctrl(cfg0);
			reg_ch0_period: rd_word[period_w-1:0] = cfg0.period;
			reg_ch1_ctrl:   rd_word = get_ctrl(cfg1);
			reg_ch1_period: rd_word[period_w-1:0] = cfg1.period;
			default:        rd_hit = 1'b0;
		endcase
	end

	// Write channel. A new request is taken only once the previous
	// response has been consumed.
	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end
		else
		begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready  <= awvalid && wvalid && !bvalid && !awready;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge base_freq)
	begin
		if (wr_fire)
			bresp <= wr_hit ? axi_resp_okay : axi_resp_slverr;
	end

	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg0 <= '0; // Both voices come up disabled.
			cfg1 <= '0;
		end
		else if (wr_fire)
		begin
			case (awaddr)
				reg_ch0_ctrl:   cfg0 <= put_ctrl(cfg0, wdata);
				reg_ch0_period: cfg0.period <= wdata[period_w-1:0];
				reg_ch1_ctrl:   cfg1 <= put_ctrl(cfg1, wdata);
				reg_ch1_period: cfg1.period <= wdata[period_w-1:0];
				default: ;
			endcase
		end
	end

	// Read channel.
	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge base_freq)
	begin
		if (rd_fire)
		begin
			rdata <= rd_word;
			rresp <= rd_hit ? axi_resp_okay : axi_resp_slverr;
		end
	end

	// A pending response must wait for the master.
	assert property (@(posedge base_freq) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge base_freq) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

//--- design/pulse_channel.sv
`timescale 1ns/10ps
`default_nettype none

module pulse_channel
	import sound_pkg::*;
(
	input  logic             base_freq,
	input  logic             rst_n,
	input  pulse_cfg_t       cfg,
	output logic [vol_w-1:0] sample
);

	logic [period_w-1:0] timer; // Cycles left until the next phase step.
	logic [phase_w-1:0]  phase;
	logic [phase_w-1:0]  threshold;

	// Duty 3 repeats the 50 percent wave.
	always_comb
	begin
		case (cfg.duty)
			2'd1:    threshold = thr_duty_75;
			2'd2:    threshold = thr_duty_87;
			default: threshold = thr_duty_50;
		endcase
	end

	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
		begin
			timer <= '0;
			phase <= '0;
		end
		else if (!cfg.enable)
		begin
			// Parked so that a new enable starts a full first step.
			timer <= cfg.period;
			phase <= '0;
		end
		else if (timer == '0)
		begin
			timer <= cfg.period;
			phase <= phase + 1'b1; // Wraps after the last of the 32 steps.
		end
		else
		begin
			timer <= timer - 1'b1;
		end
	end

	// The output is the low part of the wave, then volume until the wrap.
	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
			sample <= '0;
		else if (!cfg.enable)
			sample <= '0;
		else if (phase >= threshold)
			sample <= cfg.volume;
		else
			sample <= '0;
	end

	// A nonzero sample is the volume that was set a cycle earlier.
	assert property (@(posedge base_freq) disable iff (!rst_n)
		sample != '0 |-> sample == $past(cfg.volume))
		else $error("sample is neither zero nor the channel volume");

	assert property (@(posedge base_freq) disable iff (!rst_n)
		!cfg.enable |=> phase == '0)
		else $error("phase moved while the channel was disabled");

endmodule

`default_nettype wire

//--- design/sound_top.sv
`timescale 1ns/10ps
`default_nettype none

module sound_top
	import sound_pkg::*;
(
	input  logic                  base_freq,
	input  logic                  rst_n,
	input  logic [axi_addr_w-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [axi_data_w-1:0] wdata,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [axi_addr_w-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [axi_data_w-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output logic [mix_w-1:0]      mix_out
);

	pulse_cfg_t       cfg0;
	pulse_cfg_t       cfg1;
	logic [vol_w-1:0] sample0;
	logic [vol_w-1:0] sample1;

	sound_regs regs_inst (
		.base_freq (base_freq),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.cfg0      (cfg0),
		.cfg1      (cfg1)
	);

	pulse_channel ch0_inst (
		.base_freq (base_freq),
		.rst_n     (rst_n),
		.cfg       (cfg0),
		.sample    (sample0)
	);

	pulse_channel ch1_inst (
		.base_freq (base_freq),
		.rst_n     (rst_n),
		.cfg       (cfg1),
		.sample    (sample1)
	);

	// The extra bit keeps two full-scale voices from clipping.
	always_ff @(posedge base_freq or negedge rst_n)
	begin
		if (!rst_n)
			mix_out <= '0;
		else
			mix_out <= mix_w'(sample0) + mix_w'(sample1);
	end

endmodule

`default_nettype wire

//--- verification/sound_tb_axi.svh
// Write one register. Ready is held off for resp_delay cycles, and the same
// request is offered again meanwhile, which the slave must not accept.
task automatic axi_write(input logic [axi_addr_w-1:0] addr,
	input logic [axi_data_w-1:0] data, output logic [1:0] resp);
	@(negedge base_freq);
	awaddr  = addr;
	wdata   = data;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	do @(negedge base_freq); while (!awready); // Handshake at the next edge.
	@(negedge base_freq);
	awvalid = 1'b0;
	wvalid  = 1'b0;
	if (resp_delay > 0)
	begin
		awvalid = 1'b1;
		wvalid  = 1'b1;
		repeat (resp_delay) @(negedge base_freq);
		awvalid = 1'b0;
		wvalid  = 1'b0;
	end
	while (!bvalid) @(negedge base_freq);
	resp   = bresp;
	bready = 1'b1;
	@(negedge base_freq);
	bready = 1'b0;
endtask

task automatic axi_read(input logic [axi_addr_w-1:0] addr,
	output logic [axi_data_w-1:0] data, output logic [1:0] resp);
	@(negedge base_freq);
	araddr  = addr;
	arvalid = 1'b1;
	do @(negedge base_freq); while (!arready);
	@(negedge base_freq);
	arvalid = 1'b0;
	if (resp_delay > 0)
	begin
		arvalid = 1'b1; // A second read that must wait.
		repeat (resp_delay) @(negedge base_freq);
		arvalid = 1'b0;
	end
	while (!rvalid) @(negedge base_freq);
	data   = rdata;
	resp   = rresp;
	rready = 1'b1;
	@(negedge base_freq);
	rready = 1'b0;
endtask

//--- verification/sound_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sound_tb
	import sound_pkg::*;
();

	localparam logic [31:0] lfsr_seed = 32'hc41f_2dd9;
	localparam int small_period = 3;
	localparam int long_period  = 5;
	// Four duties of three waves each, two long mixed waves, then margin.
	localparam int timeout_cycles = 4 * 3 * steps * (small_period + 1)
		+ 2 * steps * (long_period + 1) + 2000;
	// Ctrl and period registers alternate, channel 0 first.
	localparam logic [axi_addr_w-1:0] reg_addr [4] = '{reg_ch0_ctrl, reg_ch0_period,
		reg_ch1_ctrl, reg_ch1_period};

	logic base_freq, rst_n;
	logic [axi_addr_w-1:0] awaddr, araddr;
	logic [axi_data_w-1:0] wdata, rdata;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	logic [mix_w-1:0] mix_out;

	logic [31:0] lfsr_state = lfsr_seed;
	logic [31:0] exp_reg [4];
	int errors = 0;
	int cycles = 0;
	int resp_delay = 0;
	int mode = 0; // 0 free, 1 silent, 2 one voice, 3 two voices.
	logic [mix_w-1:0] exp_v0, exp_v1, prev_mix;
	int exp_wave, exp_high, last_rise, rises;
	logic have_rise;
	logic [3:0] seen;

	sound_top sound_top_inst (.*);

	`include "sound_tb_axi.svh"

	always #10 base_freq = ~base_freq;

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int duty_threshold(input int duty);
		case (duty)
			1: return 8;
			2: return 4;
			default: return 16; // Duty 0 and duty 3 are both square waves.
		endcase
	endfunction

	function automatic logic mix_allowed(input logic [mix_w-1:0] m);
		case (mode)
			1: return m == '0;
			2: return m == '0 || m == exp_v0;
			3: return m == '0 || m == exp_v0 || m == exp_v1 || m == exp_v0 + exp_v1;
			default: return 1'b1;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, act);
		assert (exp == act)
		else
		begin
			errors++;
			$display("FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		end
	endtask

	assert property (@(posedge base_freq) disable iff (!rst_n) mix_allowed(mix_out))
	else
	begin
		errors++;
		$display("FAILED t=%0t mix_out expected a level of mode %0d got %0d",
			$time, mode, mix_out);
	end

	assert property (@(posedge base_freq) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		errors++;
		$display("FAILED t=%0t bvalid or bresp changed while waiting", $time);
	end

	assert property (@(posedge base_freq) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
	else
	begin
		errors++;
		$display("FAILED t=%0t rvalid, rresp or rdata changed", $time);
	end

	assert property (@(posedge base_freq) disable iff (!rst_n) bvalid |-> !awready && !wready)
	else
	begin
		errors++;
		$display("The slave took a write while a response was pending");
	end

	assert property (@(posedge base_freq) disable iff (!rst_n) rvalid |-> !arready)
	else
	begin
		errors++;
		$display("The slave took a read while a response was pending");
	end

	// Edge timing of the single-voice wave and the levels seen in the mix.
	always @(negedge base_freq)
	begin
		cycles++;
		if (mode == 2 && prev_mix == '0 && mix_out != '0)
		begin
			if (have_rise)
				check_value("mix_out rise spacing", exp_wave, cycles - last_rise);
			last_rise = cycles;
			have_rise = 1'b1;
			rises++;
		end
		if (mode == 2 && prev_mix != '0 && mix_out == '0 && have_rise)
			check_value("mix_out high time", exp_high, cycles - last_rise);
		if (mode == 3)
		begin
			if (mix_out == '0) seen[0] = 1'b1;
			if (mix_out == exp_v0) seen[1] = 1'b1;
			if (mix_out == exp_v1) seen[2] = 1'b1;
			if (mix_out == exp_v0 + exp_v1) seen[3] = 1'b1;
		end
		prev_mix = mix_out;
		if (cycles >= timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic verify_regs();
		logic [31:0] d;
		logic [1:0] r;
		for (int i = 0; i < 4; i++)
		begin
			axi_read(reg_addr[i], d, r);
			check_value("rdata", exp_reg[i], d);
			check_value("rresp", {30'd0, axi_resp_okay}, {30'd0, r});
		end
	endtask

	task automatic write_reg(input logic [axi_addr_w-1:0] a, input logic [31:0] d);
		logic [1:0] r;
		axi_write(a, d, r);
		check_value("bresp", {30'd0, axi_resp_okay}, {30'd0, r});
		for (int i = 0; i < 4; i++)
		begin
			if (reg_addr[i] == a)
				exp_reg[i] = d & ((i % 2) != 0 ? 32'h0000_07FF : 32'h0000_00F7);
		end
	endtask

	initial
	begin
		logic [31:0] d;
		logic [1:0] r;
		base_freq = 1'b0;
		rst_n = 1'b0;
		{awaddr, araddr, wdata} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		prev_mix = '0;
		have_rise = 1'b0;
		repeat (2) @(negedge base_freq);
		rst_n = 1'b1;
		check_value("ready and valid outputs",
			0, {awready, wready, bvalid, arready, rvalid});
		check_value("mix_out", 0, mix_out);

		for (int i = 0; i < 4; i++)
			write_reg(reg_addr[i], take_bits(32));
		verify_regs();

		axi_write(4'h2, take_bits(32), r);
		check_value("bresp", {30'd0, axi_resp_slverr}, {30'd0, r});
		axi_read(4'h6, d, r);
		check_value("rresp", {30'd0, axi_resp_slverr}, {30'd0, r});
		check_value("rdata", 0, d);
		verify_regs();

		write_reg(reg_ch0_ctrl, 0);
		write_reg(reg_ch1_ctrl, 0);
		repeat (4) @(negedge base_freq);
		mode = 1;
		repeat (50) @(negedge base_freq);

		for (int duty = 0; duty < 4; duty++)
		begin
			exp_v0 = mix_w'(take_bits(4) | 1);
			exp_wave = steps * (small_period + 1);
			exp_high = (steps - duty_threshold(duty)) * (small_period + 1);
			have_rise = 1'b0;
			rises = 0;
			mode = 2;
			write_reg(reg_ch0_period, small_period);
			write_reg(reg_ch0_ctrl, {24'd0, exp_v0[3:0], 1'b0, 2'(duty), 1'b1});
			while (rises < 3) @(negedge base_freq);
			// The third pulse runs to its end before the voice is switched off.
			while (mix_out != '0) @(negedge base_freq);
			write_reg(reg_ch0_ctrl, 0);
			while (mix_out != '0) @(negedge base_freq);
			repeat (2) @(negedge base_freq);
		end

		exp_v0 = mix_w'(take_bits(3) | 1);
		exp_v1 = exp_v0 + 5'd8; // Keeps all four mix levels distinct.
		mode = 3;
		write_reg(reg_ch0_period, 2);
		write_reg(reg_ch1_period, long_period);
		write_reg(reg_ch0_ctrl, {24'd0, exp_v0[3:0], 4'b0001});
		write_reg(reg_ch1_ctrl, {24'd0, exp_v1[3:0], 4'b0001});
		seen = '0;
		repeat (2 * steps * (long_period + 1)) @(negedge base_freq);
		check_value("mix_out levels seen", 4'hF, {28'd0, seen});

		resp_delay = 6;
		write_reg(reg_ch0_period, 2);
		axi_read(reg_ch1_ctrl, d, r);
		check_value("rdata", exp_reg[2], d);
		resp_delay = 0;
		verify_regs();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
design/sound_pkg.sv
design/sound_regs.sv
design/pulse_channel.sv
design/sound_top.sv
verification/sound_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the sound generator testbench with Verilator and runs it.
set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 --top-module sound_tb \
	-f project.f -o sound_sim 2>&1 | tee "$log"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sound_sim 2>&1 | tee -a "$log"
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error"
	exit 1
fi

if grep -q "Regression failed" "$log"; then
	exit 1
fi
exit 0
